// ==== hazard_defs.svh ====
`ifndef HAZARD_DEFS_SVH
`define HAZARD_DEFS_SVH

// GPR index width, 32 architectural registers
`define REG_ADDR_W 5

// Program counter width
`define PC_W 32

// r0 reads as zero and a write to it is dropped
`define ZERO_REG {`REG_ADDR_W{1'b0}}

`endif

// ==== regPkg.sv ====
`default_nettype none
`include "hazard_defs.svh"

package regPkg;

	typedef logic [`REG_ADDR_W-1:0] regAddr_t; // GPR index

	typedef logic [`PC_W-1:0] pc_t; // Fetch address

	// Source of an execute-stage operand
	typedef enum logic [1:0] {
		FWD_NONE = 2'b00, // Register file value
		FWD_MEM  = 2'b01, // Bypass from memory stage
		FWD_WB   = 2'b10  // Bypass from writeback
	} fwdSel_t;

endpackage

`default_nettype wire

// ==== ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	// Data cache wait tracking
	typedef enum logic {
		DC_FREE = 1'b0, // No access outstanding
		DC_BUSY = 1'b1  // Memory stage waiting on dataOk
	} dcState_t;

endpackage

`default_nettype wire

// ==== forwardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hazard_defs.svh"

module forwardUnit import regPkg::*; (
	input  regAddr_t exRs,
	input  regAddr_t exRt,
	input  regAddr_t idRs,
	input  regAddr_t idRt,
	input  regAddr_t memRd,
	input  regAddr_t wbRd,
	input  logic     memRfWr,
	input  logic     wbRfWr,
	input  logic     branchOp,
	output fwdSel_t  rsFwdSel,
	output fwdSel_t  rtFwdSel,
	output logic     branchRsFwd,
	output logic     branchRtFwd
);

	// A write to r0 never lands, so it must not be bypassed either
	function automatic logic regHit(
		input logic     wrEn,
		input regAddr_t dst,
		input regAddr_t src
	);
		return wrEn && (dst != `ZERO_REG) && (dst == src);
	endfunction

	// Youngest producer wins
	function automatic fwdSel_t pickSource(
		input logic memHit,
		input logic wbHit
	);
		if (memHit)
			return FWD_MEM;
		else if (wbHit)
			return FWD_WB;
		else
			return FWD_NONE;
	endfunction

	logic memHitRs;
	logic memHitRt;
	logic wbHitRs;
	logic wbHitRt;

	assign memHitRs = regHit(memRfWr, memRd, exRs);
	assign memHitRt = regHit(memRfWr, memRd, exRt);
	assign wbHitRs  = regHit(wbRfWr, wbRd, exRs);
	assign wbHitRt  = regHit(wbRfWr, wbRd, exRt);

	assign rsFwdSel = pickSource(memHitRs, wbHitRs); // ALU input A
	assign rtFwdSel = pickSource(memHitRt, wbHitRt); // ALU input B

	// Branch compare in decode only sees the memory stage
	assign branchRsFwd = branchOp && regHit(memRfWr, memRd, idRs);
	assign branchRtFwd = branchOp && regHit(memRfWr, memRd, idRt);

endmodule

`default_nettype wire

// ==== stallUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module stallUnit import regPkg::*, ctrlPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     bootHold,
	input  logic     icacheDataOk,
	input  logic     memException,
	input  logic     memEretFlush,
	input  logic     mulDivBusy,
	input  logic     hiLoAccess,
	input  logic     exDmRd,
	input  logic     exCp0Rd,
	input  logic     memDmRd,
	input  logic     memCp0Rd,
	input  logic     exRfWr,
	input  logic     memRfWr,
	input  logic     branchOp,
	input  logic     memDcacheEn,
	input  logic     dcacheDataOk,
	input  regAddr_t exRt,
	input  regAddr_t memRt,
	input  regAddr_t idRs,
	input  regAddr_t idRt,
	input  pc_t      idPc,
	input  pc_t      exPc,
	output logic     pcWr,
	output logic     ifIdWr,
	output logic     idExBubble,
	output logic     instReqEn,
	output logic     dcacheStall
);

	dcState_t dcState;
	dcState_t dcNext;

	logic exRtHit;
	logic memRtHit;
	logic flushReq;
	logic mulDivHaz;
	logic loadUseHaz;
	logic branchMemHaz;
	logic branchExHaz;
	logic freeze;

	// Decode sources against older destinations
	assign exRtHit  = (exRt == idRs) || (exRt == idRt);
	assign memRtHit = (memRt == idRs) || (memRt == idRt);

	assign flushReq  = memException || memEretFlush;
	assign mulDivHaz = mulDivBusy && hiLoAccess; // HI/LO not ready yet

	// Same PC in ID and EX means the decode slot is already a bubble
	assign loadUseHaz = (exDmRd || exCp0Rd) && exRtHit && (idPc != exPc);

	// Branch needs a value that is still in the load path
	assign branchMemHaz = branchOp && memRfWr && (memDmRd || memCp0Rd) && memRtHit;

	// Branch operand still being computed in execute
	assign branchExHaz = branchOp && exRfWr && exRtHit;

	always_comb begin
		if (bootHold)
			freeze = 1'b1;
		else if (!icacheDataOk)
			freeze = 1'b1; // No valid instruction back yet
		else if (flushReq)
			freeze = 1'b0; // Let the handler fetch proceed
		else if (mulDivHaz)
			freeze = 1'b1;
		else if (loadUseHaz)
			freeze = 1'b1;
		else if (branchMemHaz)
			freeze = 1'b1;
		else if (branchExHaz)
			freeze = 1'b1;
		else
			freeze = 1'b0;
	end

	assign pcWr       = !freeze;
	assign ifIdWr     = !freeze;
	assign instReqEn  = !freeze; // Hold off new fetch requests
	assign idExBubble = freeze;

	always_comb begin
		case (dcState)
			DC_FREE: begin
				if (memDcacheEn && !dcacheDataOk)
					dcNext = DC_BUSY;
				else
					dcNext = DC_FREE;
			end
			DC_BUSY: begin
				if (dcacheDataOk)
					dcNext = DC_FREE;
				else
					dcNext = DC_BUSY;
			end
			default: dcNext = DC_FREE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst)
			dcState <= DC_FREE;
		else
			dcState <= dcNext;
	end

	// Drops in the dataOk cycle itself, state follows at the edge
	assign dcacheStall = !dcacheDataOk && ((dcState == DC_BUSY) || memDcacheEn);

endmodule

`default_nettype wire

// ==== hazardControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardControl import regPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  regAddr_t exRs,
	input  regAddr_t exRt,
	input  regAddr_t idRs,
	input  regAddr_t idRt,
	input  regAddr_t memRd,
	input  regAddr_t wbRd,
	input  regAddr_t memRt,
	input  logic     memRfWr,
	input  logic     wbRfWr,
	input  logic     exRfWr,
	input  logic     exDmRd,
	input  logic     memDmRd,
	input  logic     exCp0Rd,
	input  logic     memCp0Rd,
	input  logic     branchOp,
	input  pc_t      idPc,
	input  pc_t      exPc,
	input  logic     bootHold,
	input  logic     icacheDataOk,
	input  logic     memException,
	input  logic     memEretFlush,
	input  logic     mulDivBusy,
	input  logic     hiLoAccess,
	input  logic     memDcacheEn,
	input  logic     dcacheDataOk,
	output fwdSel_t  rsFwdSel,
	output fwdSel_t  rtFwdSel,
	output logic     branchRsFwd,
	output logic     branchRtFwd,
	output logic     pcWr,
	output logic     ifIdWr,
	output logic     idExBubble,
	output logic     instReqEn,
	output logic     dcacheStall
);

	forwardUnit u_forward (
		.exRs        (exRs),
		.exRt        (exRt),
		.idRs        (idRs),
		.idRt        (idRt),
		.memRd       (memRd),
		.wbRd        (wbRd),
		.memRfWr     (memRfWr),
		.wbRfWr      (wbRfWr),
		.branchOp    (branchOp),
		.rsFwdSel    (rsFwdSel),
		.rtFwdSel    (rtFwdSel),
		.branchRsFwd (branchRsFwd),
		.branchRtFwd (branchRtFwd)
	);

	stallUnit u_stall (
		.clk          (clk),
		.rst          (rst),
		.bootHold     (bootHold),
		.icacheDataOk (icacheDataOk),
		.memException (memException),
		.memEretFlush (memEretFlush),
		.mulDivBusy   (mulDivBusy),
		.hiLoAccess   (hiLoAccess),
		.exDmRd       (exDmRd),
		.exCp0Rd      (exCp0Rd),
		.memDmRd      (memDmRd),
		.memCp0Rd     (memCp0Rd),
		.exRfWr       (exRfWr),
		.memRfWr      (memRfWr),
		.branchOp     (branchOp),
		.memDcacheEn  (memDcacheEn),
		.dcacheDataOk (dcacheDataOk),
		.exRt         (exRt),
		.memRt        (memRt),
		.idRs         (idRs),
		.idRt         (idRt),
		.idPc         (idPc),
		.exPc         (exPc),
		.pcWr         (pcWr),
		.ifIdWr       (ifIdWr),
		.idExBubble   (idExBubble),
		.instReqEn    (instReqEn),
		.dcacheStall  (dcacheStall)
	);

endmodule

`default_nettype wire

// ==== hazardControl_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stallChecker import ctrlPkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     pcWr,
	input logic     ifIdWr,
	input logic     instReqEn,
	input logic     idExBubble,
	input logic     dcacheStall,
	input logic     dcacheDataOk,
	input dcState_t dcState
);

	// Fetch and decode enables move as one
	enablesAligned: assert property (@(posedge clk) disable iff (!rst)
		pcWr == ifIdWr && pcWr == instReqEn)
		else $error("pcWr, ifIdWr and instReqEn disagree");

	bubbleInverse: assert property (@(posedge clk) disable iff (!rst)
		idExBubble == !pcWr)
		else $error("idExBubble is not the inverse of pcWr");

	// The dataOk cycle itself already drops the stall
	busyStalls: assert property (@(posedge clk) disable iff (!rst)
		(dcState == DC_BUSY && !dcacheDataOk) |-> dcacheStall)
		else $error("dcacheStall low while the data cache wait is pending");

	busyHolds: assert property (@(posedge clk) disable iff (!rst)
		(dcState == DC_BUSY && !dcacheDataOk) |=> dcState == DC_BUSY)
		else $error("data cache wait ended without dcacheDataOk");

endmodule

bind stallUnit stallChecker u_checker (
	.clk          (clk),
	.rst          (rst),
	.pcWr         (pcWr),
	.ifIdWr       (ifIdWr),
	.instReqEn    (instReqEn),
	.idExBubble   (idExBubble),
	.dcacheStall  (dcacheStall),
	.dcacheDataOk (dcacheDataOk),
	.dcState      (dcState)
);

`default_nettype wire

// ==== tb_hazardControl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hazard_defs.svh"

module tb_hazardControl import regPkg::*; ();

	localparam int RAND_CYCLES = 1500;
	localparam int CYCLE_LIMIT = 2000; // Reset, directed and random phases come to about 1550
	localparam int SEED = 24;

	logic clk;
	logic rst;
	regAddr_t exRs, exRt, idRs, idRt, memRd, wbRd, memRt;
	logic memRfWr, wbRfWr, exRfWr, exDmRd, memDmRd, exCp0Rd, memCp0Rd, branchOp;
	logic bootHold, icacheDataOk, memException, memEretFlush, mulDivBusy, hiLoAccess;
	logic memDcacheEn, dcacheDataOk;
	pc_t idPc, exPc;
	fwdSel_t rsFwdSel, rtFwdSel;
	logic branchRsFwd, branchRtFwd, pcWr, ifIdWr, idExBubble, instReqEn, dcacheStall;

	logic modelBusy = 1'b0; // Predicted data cache wait
	string testName = "reset";
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int errsAtStart = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int unsigned seedVal;

	hazardControl u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	// Memory stage is younger than writeback, so it is tried first
	function automatic fwdSel_t fwdFor(input regAddr_t src);
		if (memRfWr && memRd != `ZERO_REG && memRd == src)
			return FWD_MEM;
		if (wbRfWr && wbRd != `ZERO_REG && wbRd == src)
			return FWD_WB;
		return FWD_NONE;
	endfunction

	function automatic void predict(
		output fwdSel_t rsExp,
		output fwdSel_t rtExp,
		output logic    brRsExp,
		output logic    brRtExp,
		output logic    freezeExp,
		output logic    stallExp
	);
		logic exHit;
		logic memHit;
		logic memValid;
		exHit = (exRt == idRs) || (exRt == idRt);
		memHit = (memRt == idRs) || (memRt == idRt);
		memValid = memRfWr && memRd != `ZERO_REG;
		rsExp = fwdFor(exRs);
		rtExp = fwdFor(exRt);
		brRsExp = branchOp && memValid && memRd == idRs;
		brRtExp = branchOp && memValid && memRd == idRt;
		if (bootHold || !icacheDataOk)
			freezeExp = 1'b1;
		else if (memException || memEretFlush)
			freezeExp = 1'b0; // Flush wins over every hazard below
		else
			freezeExp = (mulDivBusy && hiLoAccess)
				|| ((exDmRd || exCp0Rd) && exHit && idPc != exPc)
				|| (branchOp && memRfWr && (memDmRd || memCp0Rd) && memHit)
				|| (branchOp && exRfWr && exHit);
		stallExp = !dcacheDataOk && (modelBusy || memDcacheEn);
	endfunction

	task automatic checkFwd(input string sig, input fwdSel_t exp, input fwdSel_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %s, actual %s", testName, sig, exp.name(), act.name());
		end
	endtask

	task automatic checkBit(input string sig, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %b, actual %b", testName, sig, exp, act);
		end
	endtask

	// Inputs settle 1 ns after the rising edge, so the falling edge sees stable outputs
	always @(negedge clk) begin
		fwdSel_t rsExp;
		fwdSel_t rtExp;
		logic brRsExp;
		logic brRtExp;
		logic freezeExp;
		logic stallExp;
		predict(rsExp, rtExp, brRsExp, brRtExp, freezeExp, stallExp);
		checkFwd("rsFwdSel", rsExp, rsFwdSel);
		checkFwd("rtFwdSel", rtExp, rtFwdSel);
		checkBit("branchRsFwd", brRsExp, branchRsFwd);
		checkBit("branchRtFwd", brRtExp, branchRtFwd);
		checkBit("pcWr", !freezeExp, pcWr);
		checkBit("ifIdWr", !freezeExp, ifIdWr);
		checkBit("instReqEn", !freezeExp, instReqEn);
		checkBit("idExBubble", freezeExp, idExBubble);
		checkBit("dcacheStall", stallExp, dcacheStall);
		if (!rst)
			modelBusy <= 1'b0;
		else if (modelBusy)
			modelBusy <= !dcacheDataOk;
		else
			modelBusy <= memDcacheEn && !dcacheDataOk;
	end

	// Rt in execute and memory matches idRs, so one read flag makes a hazard
	task automatic idleInputs();
		{exRs, wbRd, memRd} = '0;
		{exRt, memRt, idRs} = {3{5'd7}};
		idRt = 5'd3;
		{memRfWr, wbRfWr, exRfWr, exDmRd, memDmRd, exCp0Rd, memCp0Rd, branchOp} = '0;
		{bootHold, memException, memEretFlush, mulDivBusy, hiLoAccess} = '0;
		{memDcacheEn, dcacheDataOk} = '0;
		icacheDataOk = 1'b1;
		idPc = 32'h4;
		exPc = 32'h0;
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#1;
		idleInputs();
	endtask

	task automatic regVec(input regAddr_t rs, input regAddr_t rt, input regAddr_t ids,
		input regAddr_t idt, input regAddr_t md, input regAddr_t wd,
		input logic mw, input logic ww, input logic br);
		nextCycle();
		{exRs, exRt, idRs, idRt, memRd, wbRd} = {rs, rt, ids, idt, md, wd};
		{memRfWr, wbRfWr, branchOp} = {mw, ww, br};
	endtask

	// Random indices stay small most of the time so that they collide
	function automatic regAddr_t randReg();
		if ($urandom_range(0, 7) == 0)
			return regAddr_t'($urandom_range(0, 31));
		return regAddr_t'($urandom_range(0, 3));
	endfunction

	task automatic startTest(input string name);
		testName = name;
		errsAtStart = errors;
	endtask

	task automatic endTest();
		@(negedge clk);
		#1;
		testsRun++;
		if (errors != errsAtStart) begin
			testsFailed++;
			$display("Test %s: failed with %0d errors", testName, errors - errsAtStart);
		end else begin
			$display("Test %s: passed", testName);
		end
	endtask

	initial begin
		seedVal = $urandom(SEED);
		rst = 1'b0;
		idleInputs();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b1;

		startTest("execForward");
		regVec(5'd3, 5'd5, 5'd0, 5'd0, 5'd3, 5'd5, 1'b1, 1'b1, 1'b0);
		regVec(5'd3, 5'd3, 5'd0, 5'd0, 5'd3, 5'd3, 1'b1, 1'b1, 1'b0);
		regVec(5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1, 1'b0);
		regVec(5'd3, 5'd3, 5'd0, 5'd0, 5'd3, 5'd3, 1'b0, 1'b0, 1'b0);
		regVec(5'd3, 5'd3, 5'd0, 5'd0, 5'd3, 5'd3, 1'b0, 1'b1, 1'b0);
		endTest();

		startTest("branchBypass");
		regVec(5'd0, 5'd0, 5'd6, 5'd6, 5'd6, 5'd0, 1'b1, 1'b0, 1'b1);
		regVec(5'd0, 5'd0, 5'd6, 5'd6, 5'd6, 5'd0, 1'b1, 1'b0, 1'b0);
		regVec(5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0, 1'b1);
		regVec(5'd0, 5'd0, 5'd6, 5'd4, 5'd6, 5'd0, 1'b1, 1'b0, 1'b1);
		endTest();

		startTest("loadUse");
		nextCycle();
		exDmRd = 1'b1;
		nextCycle();
		exCp0Rd = 1'b1;
		{idRs, idRt} = {5'd3, 5'd7};
		nextCycle();
		exDmRd = 1'b1;
		exPc = idPc; // Decode slot already a bubble
		nextCycle();
		exDmRd = 1'b1;
		exRt = 5'd9;
		endTest();

		startTest("priority");
		nextCycle();
		{icacheDataOk, memException} = 2'b01;
		nextCycle();
		{memException, exDmRd, mulDivBusy, hiLoAccess} = 4'hf;
		nextCycle();
		{memEretFlush, exDmRd} = 2'b11;
		nextCycle();
		{bootHold, memException} = 2'b11;
		nextCycle();
		{mulDivBusy, hiLoAccess} = 2'b11;
		endTest();

		startTest("branchHazard");
		nextCycle();
		{branchOp, memDmRd, memRfWr} = 3'b111;
		nextCycle();
		{memDmRd, memRfWr} = 2'b11;
		nextCycle();
		{branchOp, exRfWr} = 2'b11;
		nextCycle();
		exRfWr = 1'b1;
		nextCycle();
		{branchOp, memCp0Rd} = 2'b11; // No register write, so no freeze
		endTest();

		startTest("dcacheWait");
		nextCycle();
		memDcacheEn = 1'b1;
		repeat (2) nextCycle();
		nextCycle();
		dcacheDataOk = 1'b1;
		nextCycle();
		nextCycle();
		{memDcacheEn, dcacheDataOk} = 2'b11;
		nextCycle();
		memDcacheEn = 1'b1;
		nextCycle();
		rst = 1'b0; // Pending wait clears at the reset edge
		nextCycle();
		rst = 1'b1;
		endTest();

		startTest("random");
		repeat (RAND_CYCLES) begin
			nextCycle();
			{exRs, exRt, idRs, idRt} = {randReg(), randReg(), randReg(), randReg()};
			{memRd, wbRd, memRt} = {randReg(), randReg(), randReg()};
			{memRfWr, wbRfWr, exRfWr, exDmRd, memDmRd, exCp0Rd, memCp0Rd, branchOp} = 8'($urandom);
			{mulDivBusy, hiLoAccess, memDcacheEn, dcacheDataOk} = 4'($urandom);
			bootHold = ($urandom_range(0, 15) == 0);
			icacheDataOk = ($urandom_range(0, 7) != 0);
			memException = ($urandom_range(0, 15) == 0);
			memEretFlush = ($urandom_range(0, 15) == 0);
			idPc = pc_t'($urandom_range(0, 3) * 4);
			exPc = pc_t'($urandom_range(0, 3) * 4);
		end
		endTest();

		$display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
regPkg.sv
ctrlPkg.sv
forwardUnit.sv
stallUnit.sv
hazardControl.sv
hazardControl_checker.sv
tb_hazardControl.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the hazard control testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_hazardControl -o tb_hazardControl
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_hazardControl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	echo "Simulation reported errors, see $LOG"
	exit 1
fi
exit 0
